/* design/remap_consts.svh */
// ==============================
// Widths and limits of the AXI read ID remapper
// The slot count is 2**REMAP_OUT_ID_W and is not set on its own
// REMAP_MAX_TXN must fit in REMAP_CNT_W bits
// ==============================

`ifndef REMAP_CONSTS_SVH
`define REMAP_CONSTS_SVH

`define REMAP_IN_ID_W  4
`define REMAP_OUT_ID_W 2

`define REMAP_ADDR_W   32
`define REMAP_DATA_W   32
`define REMAP_LEN_W    8

// Outstanding transactions allowed per downstream ID
`define REMAP_MAX_TXN  7
`define REMAP_CNT_W    3

`endif

/* design/remap_pkg.sv */
// ==============================
// Types shared by the remapper and its testbench
// Widths come from remap_consts.svh
// ==============================

`include "remap_consts.svh"

package remap_pkg;

  // Upstream and downstream IDs, the downstream ID is also the slot index
  typedef logic [`REMAP_IN_ID_W-1:0]  in_id_t;
  typedef logic [`REMAP_OUT_ID_W-1:0] out_id_t;

  typedef logic [`REMAP_ADDR_W-1:0]   addr_t;
  typedef logic [`REMAP_DATA_W-1:0]   data_t;
  typedef logic [`REMAP_LEN_W-1:0]    len_t;

  typedef logic [`REMAP_CNT_W-1:0]    txn_cnt_t;

  // Input stage FSM
  typedef enum logic [1:0] {
    IDLE,
    HOLD,
    ISSUE
  } in_state_e;

endpackage

/* design/ar_remap_in.sv */
`timescale 1ns/1ns
// ==============================
// AR input stage, one request in flight at a time
// Upstream ready is high only while idle
// Downstream ID is latched on entry to ISSUE and held until the transfer
// ==============================

module ar_remap_in (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Upstream AR
  input  logic               s_ar_valid_i,
  output logic               s_ar_ready_o,
  input  remap_pkg::in_id_t  s_ar_id_i,
  input  remap_pkg::addr_t   s_ar_addr_i,
  input  remap_pkg::len_t    s_ar_len_i,
  // Downstream AR
  output logic               m_ar_valid_o,
  input  logic               m_ar_ready_i,
  output remap_pkg::out_id_t m_ar_id_o,
  output remap_pkg::addr_t   m_ar_addr_o,
  output remap_pkg::len_t    m_ar_len_o,
  // Slot table lookup
  output remap_pkg::in_id_t  lookup_id_o,
  input  remap_pkg::out_id_t lookup_slot_i,
  input  logic               lookup_avail_i,
  output logic               alloc_o
);

  remap_pkg::in_state_e state_q;
  remap_pkg::in_state_e state_d;

  remap_pkg::in_id_t    id_q;
  remap_pkg::addr_t     addr_q;
  remap_pkg::len_t      len_q;
  remap_pkg::out_id_t   slot_q;

  logic s_ar_fire;
  logic m_ar_fire;
  logic take_slot;

  assign s_ar_ready_o = (state_q == remap_pkg::IDLE);
  assign s_ar_fire    = s_ar_valid_i && s_ar_ready_o;

  assign m_ar_valid_o = (state_q == remap_pkg::ISSUE);
  assign m_ar_fire    = m_ar_valid_o && m_ar_ready_i;

  // Table counts the transaction on the downstream handshake
  assign alloc_o = m_ar_fire;

  // While idle, look up the incoming ID so an accepted request
  // can skip HOLD when a slot is ready
  assign lookup_id_o = s_ar_ready_o ? s_ar_id_i : id_q;

  assign take_slot = lookup_avail_i &&
                     (s_ar_fire || (state_q == remap_pkg::HOLD));

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      remap_pkg::IDLE: begin
        if (s_ar_fire) begin
          state_d = lookup_avail_i ? remap_pkg::ISSUE : remap_pkg::HOLD;
        end
      end
      remap_pkg::HOLD: begin
        // Wait for a release to free room in the table
        if (lookup_avail_i) begin
          state_d = remap_pkg::ISSUE;
        end
      end
      remap_pkg::ISSUE: begin
        if (m_ar_ready_i) begin
          state_d = remap_pkg::IDLE;
        end
      end
      default: begin
        state_d = remap_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin : state_reg
    if (!arst_n_i) begin
      state_q <= remap_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin : payload_reg
    if (s_ar_fire) begin
      id_q   <= s_ar_id_i;
      addr_q <= s_ar_addr_i;
      len_q  <= s_ar_len_i;
    end
    if (take_slot) begin
      slot_q <= lookup_slot_i;
    end
  end

  assign m_ar_id_o   = slot_q;
  assign m_ar_addr_o = addr_q;
  assign m_ar_len_o  = len_q;

  // Downstream payload holds under back-pressure
  a_ar_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_ar_valid_o && !m_ar_ready_i |=> m_ar_valid_o && $stable(m_ar_id_o) &&
      $stable(m_ar_addr_o) && $stable(m_ar_len_o));

  // The table must count the same slot that goes out as the downstream ID
  a_alloc_slot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    alloc_o |-> lookup_slot_i == m_ar_id_o);

endmodule

/* design/remap_table.sv */
`timescale 1ns/1ns
`include "remap_consts.svh"
// ==============================
// Slot table, one entry per downstream ID
// A busy slot keeps one upstream ID until its count returns to zero
// Alloc takes the slot given by the current lookup
// ==============================

module remap_table (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // AR side
  input  remap_pkg::in_id_t  lookup_id_i,
  output remap_pkg::out_id_t lookup_slot_o,
  output logic               lookup_avail_o,
  input  logic               alloc_i,
  // R side
  input  remap_pkg::out_id_t rel_slot_i,
  output remap_pkg::in_id_t  rel_orig_id_o,
  input  logic               release_i
);

  localparam int NUM_SLOTS = 1 << `REMAP_OUT_ID_W;

  logic                busy_q [NUM_SLOTS];
  remap_pkg::in_id_t   orig_q [NUM_SLOTS];
  remap_pkg::txn_cnt_t cnt_q  [NUM_SLOTS];

  // Last slot handed out, kept while it stays usable
  remap_pkg::out_id_t  hint_q;

  logic                match_found;
  logic                free_found;
  remap_pkg::out_id_t  match_slot;
  remap_pkg::out_id_t  free_slot;

  logic [NUM_SLOTS-1:0] slot_inc;
  logic [NUM_SLOTS-1:0] slot_dec;
  logic                 dup_id;

  // Priority search, the loop runs downward so the lowest free slot wins
  always_comb begin : find_slot
    match_found = 1'b0;
    free_found  = 1'b0;
    match_slot  = '0;
    free_slot   = '0;
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (busy_q[i] && (orig_q[i] == lookup_id_i)) begin
        match_found = 1'b1;
        match_slot  = remap_pkg::out_id_t'(i);
      end
      if (!busy_q[i]) begin
        free_found = 1'b1;
        free_slot  = remap_pkg::out_id_t'(i);
      end
    end
  end

  // A held request keeps its slot even when a release frees a lower one
  always_comb begin : pick_slot
    if (match_found) begin
      lookup_slot_o  = match_slot;
      lookup_avail_o = (cnt_q[match_slot] < remap_pkg::txn_cnt_t'(`REMAP_MAX_TXN));
    end else if (!busy_q[hint_q]) begin
      lookup_slot_o  = hint_q;
      lookup_avail_o = 1'b1;
    end else begin
      lookup_slot_o  = free_slot;
      lookup_avail_o = free_found;
    end
  end

  always_comb begin : slot_events
    for (int i = 0; i < NUM_SLOTS; i++) begin
      slot_inc[i] = alloc_i && (lookup_slot_o == remap_pkg::out_id_t'(i));
      slot_dec[i] = release_i && (rel_slot_i == remap_pkg::out_id_t'(i));
    end
  end

  // Alloc and release on one slot in one cycle cancel out
  always_ff @(posedge clk_i or negedge arst_n_i) begin : count_update
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        busy_q[i] <= 1'b0;
        cnt_q[i]  <= '0;
      end
      hint_q <= '0;
    end else begin
      hint_q <= lookup_slot_o;
      for (int i = 0; i < NUM_SLOTS; i++) begin
        if (slot_inc[i] && !slot_dec[i]) begin
          cnt_q[i]  <= cnt_q[i] + 1'b1;
          busy_q[i] <= 1'b1;
        end else if (slot_dec[i] && !slot_inc[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
          if (cnt_q[i] == remap_pkg::txn_cnt_t'(1)) begin
            busy_q[i] <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : orig_update
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (slot_inc[i]) begin
        orig_q[i] <= lookup_id_i;
      end
    end
  end

  assign rel_orig_id_o = orig_q[rel_slot_i];

  always_comb begin : dup_check
    dup_id = 1'b0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      for (int j = i + 1; j < NUM_SLOTS; j++) begin
        if (busy_q[i] && busy_q[j] && (orig_q[i] == orig_q[j])) begin
          dup_id = 1'b1;
        end
      end
    end
  end

  // A last R beat only ever arrives for a slot with a recorded original ID
  a_release_busy : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    release_i |-> busy_q[rel_slot_i]);

  a_alloc_avail : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    alloc_i |-> lookup_avail_o);

  // Same-ID ordering relies on one slot per upstream ID
  a_unique_orig : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !dup_id);

endmodule

/* design/r_remap_out.sv */
`timescale 1ns/1ns
// ==============================
// R output stage, purely combinational
// Valid, ready and payload pass straight through
// Only the ID is swapped back to the upstream value
// ==============================

module r_remap_out (
  // Downstream R
  input  logic               m_r_valid_i,
  output logic               m_r_ready_o,
  input  remap_pkg::out_id_t m_r_id_i,
  input  remap_pkg::data_t   m_r_data_i,
  input  logic               m_r_last_i,
  // Upstream R
  output logic               s_r_valid_o,
  input  logic               s_r_ready_i,
  output remap_pkg::in_id_t  s_r_id_o,
  output remap_pkg::data_t   s_r_data_o,
  output logic               s_r_last_o,
  // Slot table release
  output remap_pkg::out_id_t rel_slot_o,
  input  remap_pkg::in_id_t  rel_orig_id_i,
  output logic               release_o
);

  logic r_fire;

  assign s_r_valid_o = m_r_valid_i;
  assign m_r_ready_o = s_r_ready_i;
  assign r_fire      = m_r_valid_i && s_r_ready_i;

  // Downstream ID selects the slot, the table answers with the original ID
  assign rel_slot_o = m_r_id_i;
  assign s_r_id_o   = rel_orig_id_i;

  assign s_r_data_o = m_r_data_i;
  assign s_r_last_o = m_r_last_i;

  // One release per completed burst
  assign release_o = r_fire && m_r_last_i;

endmodule

/* design/axi_id_remap.sv */
`timescale 1ns/1ns
// ==============================
// AXI read ID remapper, 4-bit upstream IDs onto 2-bit downstream IDs
// Read channels only, no response codes or user signals
// At most one AR is in flight inside the remapper
// ==============================

module axi_id_remap (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Upstream slave AR
  input  logic               s_ar_valid_i,
  output logic               s_ar_ready_o,
  input  remap_pkg::in_id_t  s_ar_id_i,
  input  remap_pkg::addr_t   s_ar_addr_i,
  input  remap_pkg::len_t    s_ar_len_i,
  // Upstream R
  output logic               s_r_valid_o,
  input  logic               s_r_ready_i,
  output remap_pkg::in_id_t  s_r_id_o,
  output remap_pkg::data_t   s_r_data_o,
  output logic               s_r_last_o,
  // Downstream master AR
  output logic               m_ar_valid_o,
  input  logic               m_ar_ready_i,
  output remap_pkg::out_id_t m_ar_id_o,
  output remap_pkg::addr_t   m_ar_addr_o,
  output remap_pkg::len_t    m_ar_len_o,
  // Downstream R
  input  logic               m_r_valid_i,
  output logic               m_r_ready_o,
  input  remap_pkg::out_id_t m_r_id_i,
  input  remap_pkg::data_t   m_r_data_i,
  input  logic               m_r_last_i
);

  remap_pkg::in_id_t  lookup_id;
  remap_pkg::out_id_t lookup_slot;
  logic               lookup_avail;
  logic               alloc;
  remap_pkg::out_id_t rel_slot;
  remap_pkg::in_id_t  rel_orig_id;
  logic               slot_release;

  ar_remap_in u_in (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .s_ar_valid_i   (s_ar_valid_i),
    .s_ar_ready_o   (s_ar_ready_o),
    .s_ar_id_i      (s_ar_id_i),
    .s_ar_addr_i    (s_ar_addr_i),
    .s_ar_len_i     (s_ar_len_i),
    .m_ar_valid_o   (m_ar_valid_o),
    .m_ar_ready_i   (m_ar_ready_i),
    .m_ar_id_o      (m_ar_id_o),
    .m_ar_addr_o    (m_ar_addr_o),
    .m_ar_len_o     (m_ar_len_o),
    .lookup_id_o    (lookup_id),
    .lookup_slot_i  (lookup_slot),
    .lookup_avail_i (lookup_avail),
    .alloc_o        (alloc)
  );

  remap_table u_table (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .lookup_id_i    (lookup_id),
    .lookup_slot_o  (lookup_slot),
    .lookup_avail_o (lookup_avail),
    .alloc_i        (alloc),
    .rel_slot_i     (rel_slot),
    .rel_orig_id_o  (rel_orig_id),
    .release_i      (slot_release)
  );

  r_remap_out u_out (
    .m_r_valid_i    (m_r_valid_i),
    .m_r_ready_o    (m_r_ready_o),
    .m_r_id_i       (m_r_id_i),
    .m_r_data_i     (m_r_data_i),
    .m_r_last_i     (m_r_last_i),
    .s_r_valid_o    (s_r_valid_o),
    .s_r_ready_i    (s_r_ready_i),
    .s_r_id_o       (s_r_id_o),
    .s_r_data_o     (s_r_data_o),
    .s_r_last_o     (s_r_last_o),
    .rel_slot_o     (rel_slot),
    .rel_orig_id_i  (rel_orig_id),
    .release_o      (slot_release)
  );

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ns
// ==============================
// Free running testbench clock
// PERIOD_NS should be even
// ==============================

module tb_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* tb/remap_scoreboard.sv */
`timescale 1ns/1ns
`include "remap_consts.svh"
// ==============================
// Scoreboard across the remapper, samples on the rising edge
// Expects at most one AR in flight between upstream and downstream
// ==============================

module remap_scoreboard (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               s_ar_valid_i,
  input  logic               s_ar_ready_i,
  input  remap_pkg::in_id_t  s_ar_id_i,
  input  remap_pkg::addr_t   s_ar_addr_i,
  input  remap_pkg::len_t    s_ar_len_i,
  input  logic               m_ar_valid_i,
  input  logic               m_ar_ready_i,
  input  remap_pkg::out_id_t m_ar_id_i,
  input  remap_pkg::addr_t   m_ar_addr_i,
  input  remap_pkg::len_t    m_ar_len_i,
  input  logic               s_r_valid_i,
  input  logic               s_r_ready_i,
  input  remap_pkg::in_id_t  s_r_id_i,
  input  remap_pkg::data_t   s_r_data_i,
  input  logic               s_r_last_i,
  input  remap_pkg::out_id_t m_r_id_i,
  input  logic               m_r_valid_i,
  input  logic               m_r_ready_i,
  output logic               end_of_sim_o,
  output int                 err_cnt_o
);

  remap_pkg::in_id_t  pend_id   [$];
  remap_pkg::addr_t   pend_addr [$];
  remap_pkg::len_t    pend_len  [$];
  // Open requests per upstream ID, oldest first
  remap_pkg::addr_t   open_addr [16][$];
  remap_pkg::len_t    open_len  [16][$];
  int                 beat_cnt  [16];
  int                 id_cnt    [16];
  remap_pkg::out_id_t id_slot   [16];
  remap_pkg::in_id_t  slot_owner [4];
  int                 slot_cnt  [4];
  int                 open_total;

  initial begin
    err_cnt_o  = 0;
    open_total = 0;
    for (int i = 0; i < 16; i++) begin
      beat_cnt[i] = 0;
      id_cnt[i]   = 0;
    end
    for (int i = 0; i < 4; i++) begin
      slot_cnt[i] = 0;
    end
  end

  assign end_of_sim_o = (pend_id.size() == 0) && (open_total == 0);

  task automatic report_mismatch(input string name, input longint exp, input longint act);
    $display("ERROR %s expected 0x%0h actual 0x%0h", name, exp, act);
    err_cnt_o++;
  endtask

  always @(posedge clk_i) begin : monitor
    remap_pkg::in_id_t x;
    remap_pkg::addr_t  exp_addr;
    remap_pkg::len_t   exp_len;
    int                slot;
    if (arst_n_i) begin
      // R handshake passes through the remapper unchanged
      assert (s_r_valid_i == m_r_valid_i)
        else report_mismatch("r_valid_pass", m_r_valid_i, s_r_valid_i);
      assert (m_r_ready_i == s_r_ready_i)
        else report_mismatch("r_ready_pass", s_r_ready_i, m_r_ready_i);
    end
    if (arst_n_i && m_ar_valid_i && m_ar_ready_i) begin
      slot = int'(m_ar_id_i);
      if (pend_id.size() == 0) begin
        $display("ERROR downstream AR without a pending upstream request");
        err_cnt_o++;
      end else begin
        x = pend_id.pop_front();
        exp_addr = pend_addr.pop_front();
        exp_len = pend_len.pop_front();
        assert (m_ar_addr_i == exp_addr) else report_mismatch("ar_addr", exp_addr, m_ar_addr_i);
        assert (m_ar_len_i == exp_len) else report_mismatch("ar_len", exp_len, m_ar_len_i);
        if (id_cnt[x] > 0) begin
          assert (m_ar_id_i == id_slot[x]) else report_mismatch("same_id_slot", id_slot[x], slot);
        end else begin
          // A new upstream ID must land on a slot nobody owns
          assert (slot_cnt[slot] == 0) else report_mismatch("slot_free", 0, slot_cnt[slot]);
        end
        assert (slot_cnt[slot] < `REMAP_MAX_TXN)
          else report_mismatch("slot_limit", `REMAP_MAX_TXN - 1, slot_cnt[slot]);
        id_slot[x] = m_ar_id_i;
        slot_owner[slot] = x;
        slot_cnt[slot]++;
        id_cnt[x]++;
        open_total++;
        open_addr[x].push_back(exp_addr);
        open_len[x].push_back(exp_len);
      end
    end
    if (arst_n_i && s_r_valid_i && s_r_ready_i) begin
      slot = int'(m_r_id_i);
      if (slot_cnt[slot] == 0) begin
        $display("ERROR R beat returned on a downstream ID with nothing outstanding");
        err_cnt_o++;
      end else begin
        x = slot_owner[slot];
        assert (s_r_id_i == x) else report_mismatch("r_id", x, s_r_id_i);
        exp_addr = open_addr[x][0] + remap_pkg::addr_t'(beat_cnt[x]);
        assert (s_r_data_i == exp_addr) else report_mismatch("r_data", exp_addr, s_r_data_i);
        assert (s_r_last_i == (beat_cnt[x] == int'(open_len[x][0])))
          else report_mismatch("r_last", beat_cnt[x] == int'(open_len[x][0]), s_r_last_i);
        if (beat_cnt[x] == int'(open_len[x][0])) begin
          void'(open_addr[x].pop_front());
          void'(open_len[x].pop_front());
          beat_cnt[x] = 0;
          id_cnt[x]--;
          slot_cnt[slot]--;
          open_total--;
        end else begin
          beat_cnt[x]++;
        end
      end
    end
    if (arst_n_i && s_ar_valid_i && s_ar_ready_i) begin
      pend_id.push_back(s_ar_id_i);
      pend_addr.push_back(s_ar_addr_i);
      pend_len.push_back(s_ar_len_i);
    end
  end

endmodule

/* tb/tb_axi_id_remap.sv */
`timescale 1ns/1ns
// ==============================
// Testbench for the AXI read ID remapper
// Random traffic, then slot exhaustion and per-slot limit cases
// ==============================

module tb_axi_id_remap;

  localparam int NUM_RAND = 60;
  localparam int NUM_TXN  = NUM_RAND + 5 + 8;

  logic clk_i;
  logic arst_n_i;
  logic s_ar_valid_i, s_ar_ready_o, s_r_valid_o, s_r_ready_i, s_r_last_o;
  logic m_ar_valid_o, m_ar_ready_i, m_r_valid_i, m_r_ready_o, m_r_last_i;
  remap_pkg::in_id_t  s_ar_id_i, s_r_id_o;
  remap_pkg::out_id_t m_ar_id_o, m_r_id_i;
  remap_pkg::addr_t   s_ar_addr_i, m_ar_addr_o;
  remap_pkg::len_t    s_ar_len_i, m_ar_len_o;
  remap_pkg::data_t   s_r_data_o, m_r_data_i;
  logic end_of_sim;
  int   sb_errs;
  int   tb_errs;
  int   seed;
  // Downstream responder state, {len, addr} per burst
  logic [39:0] rsp_q [4][$];
  logic        hold_rsp;
  logic        r_active;
  int          r_beat;
  int          r_id;
  int          ar_issued;
  int          bursts_done;

  tb_clk_gen #(.PERIOD_NS(4)) u_clk (.clk_o(clk_i));

  axi_id_remap u_dut (.*);

  remap_scoreboard u_sb (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .s_ar_valid_i(s_ar_valid_i), .s_ar_ready_i(s_ar_ready_o), .s_ar_id_i(s_ar_id_i),
    .s_ar_addr_i(s_ar_addr_i), .s_ar_len_i(s_ar_len_i),
    .m_ar_valid_i(m_ar_valid_o), .m_ar_ready_i(m_ar_ready_i), .m_ar_id_i(m_ar_id_o),
    .m_ar_addr_i(m_ar_addr_o), .m_ar_len_i(m_ar_len_o),
    .s_r_valid_i(s_r_valid_o), .s_r_ready_i(s_r_ready_i), .s_r_id_i(s_r_id_o),
    .s_r_data_i(s_r_data_o), .s_r_last_i(s_r_last_o), .m_r_id_i(m_r_id_i),
    .m_r_valid_i(m_r_valid_i), .m_r_ready_i(m_r_ready_o),
    .end_of_sim_o(end_of_sim), .err_cnt_o(sb_errs)
  );

  always @(posedge clk_i) begin : responder_track
    if (arst_n_i && m_ar_valid_o && m_ar_ready_i) begin
      rsp_q[m_ar_id_o].push_back({m_ar_len_o, m_ar_addr_o});
      ar_issued++;
    end
    if (arst_n_i && m_r_valid_i && m_r_ready_o) begin
      if (m_r_last_i) begin
        void'(rsp_q[m_r_id_i].pop_front());
        r_active = 1'b0;
        bursts_done++;
      end else begin
        r_beat++;
      end
    end
  end

  // Picks a random non-empty downstream ID, keeps order within one ID
  always @(negedge clk_i) begin : responder_drive
    int start;
    m_ar_ready_i = arst_n_i && ($random(seed) % 4 != 0);
    s_r_ready_i  = arst_n_i && ($random(seed) % 3 != 0);
    if (arst_n_i && !r_active && !hold_rsp) begin
      start = $unsigned($random(seed)) % 4;
      for (int k = 0; k < 4; k++) begin
        if (!r_active && rsp_q[(start + k) % 4].size() != 0) begin
          r_active = 1'b1;
          r_id     = (start + k) % 4;
          r_beat   = 0;
        end
      end
    end
    m_r_valid_i = r_active;
    if (r_active) begin
      m_r_id_i   = remap_pkg::out_id_t'(r_id);
      m_r_data_i = rsp_q[r_id][0][31:0] + remap_pkg::data_t'(r_beat);
      m_r_last_i = (r_beat == int'(rsp_q[r_id][0][39:32]));
    end
  end

  task automatic send_ar(input int id, input int len);
    @(negedge clk_i);
    s_ar_valid_i = 1'b1;
    s_ar_id_i    = remap_pkg::in_id_t'(id);
    s_ar_addr_i  = {$random(seed)} & 32'hffff_ff00;
    s_ar_len_i   = remap_pkg::len_t'(len);
    while (!s_ar_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    s_ar_valid_i = 1'b0;
  endtask

  // No request left inside the remapper and every issued burst answered
  task automatic wait_drained();
    while (!(s_ar_ready_o && (bursts_done == ar_issued))) @(negedge clk_i);
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    assert (act == exp) else begin
      $display("ERROR %s expected %0d actual %0d", name, exp, act);
      tb_errs++;
    end
  endtask

  initial begin : watchdog
    #(NUM_TXN * 200 * 4 + 200);
    $display("Timeout, the remapper or the responder stopped making progress");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    int done_before;
    seed = 81422;
    tb_errs = 0;
    ar_issued = 0;
    bursts_done = 0;
    hold_rsp = 1'b0;
    r_active = 1'b0;
    r_beat = 0;
    r_id = 0;
    arst_n_i = 1'b0;
    s_ar_valid_i = 1'b0;
    s_ar_id_i = '0;
    s_ar_addr_i = '0;
    s_ar_len_i = '0;
    s_r_ready_i = 1'b0;
    m_ar_ready_i = 1'b0;
    m_r_valid_i = 1'b0;
    m_r_id_i = '0;
    m_r_data_i = '0;
    m_r_last_i = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    check_count("reset_m_ar_valid", 0, m_ar_valid_o);
    check_count("reset_s_ar_ready", 1, s_ar_ready_o);

    for (int n = 0; n < NUM_RAND; n++) begin
      send_ar($unsigned($random(seed)) % 8, $unsigned($random(seed)) % 4);
    end
    wait_drained();

    // Four distinct IDs fill the table, a fifth must wait for a last beat
    hold_rsp = 1'b1;
    for (int id = 1; id <= 4; id++) send_ar(id, 1);
    while (ar_issued < NUM_RAND + 4) @(negedge clk_i);
    send_ar(5, 0);
    repeat (20) @(negedge clk_i);
    check_count("exhaust_issued", NUM_RAND + 4, ar_issued);
    done_before = bursts_done;
    hold_rsp = 1'b0;
    while (ar_issued < NUM_RAND + 5) @(negedge clk_i);
    assert (bursts_done > done_before) else begin
      $display("ERROR fifth ID was issued before any burst completed");
      tb_errs++;
    end
    wait_drained();

    // Eight requests on one ID, only seven may go out
    hold_rsp = 1'b1;
    for (int n = 0; n < 8; n++) send_ar(9, 0);
    repeat (20) @(negedge clk_i);
    check_count("slot_limit_issued", NUM_RAND + 12, ar_issued);
    hold_rsp = 1'b0;
    wait_drained();
    repeat (5) @(negedge clk_i);

    check_count("issued_total", NUM_TXN, ar_issued);
    check_count("end_of_sim", 1, end_of_sim);
    $display("Errors: scoreboard %0d, testbench %0d", sb_errs, tb_errs);
    if (sb_errs == 0 && tb_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+design
design/remap_pkg.sv
design/ar_remap_in.sv
design/remap_table.sv
design/r_remap_out.sv
design/axi_id_remap.sv
tb/tb_clk_gen.sv
tb/remap_scoreboard.sv
tb/tb_axi_id_remap.sv

/* run.sh */
#!/bin/sh
# Build and run the AXI read ID remapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module tb_axi_id_remap -f src.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
exit 1
